/* soc_bus.f */
source/soc_bus_pkg.sv
source/reset_debounce.sv
source/addr_decoder.sv
source/intr_controller.sv
source/bus_switch.sv
source/soc_bus_top.sv
test/clock_gen.sv
test/soc_bus_sva.sv
test/soc_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the system bus testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim

# the log decides the verdict, the simulator status is not trusted alone
./obj_dir/soc_bus_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* test/soc_bus_tb.sv */
// system bus testbench driving directed cycles through every slave window and the interrupt path
`timescale 1ns/10ps

module slave_model #(
  parameter int                 WAIT_CYCLES = 0,
  parameter soc_bus_pkg::word_t TAG         = '0
) (
  input  logic               clk,
  input  logic               rst_lck,
  input  logic               cyc_i,
  input  logic               stb_i,
  input  soc_bus_pkg::word_t rand_i,
  output logic               ack_o,
  output soc_bus_pkg::word_t rdat_o
);

  int wait_cnt;

  assign rdat_o = TAG ^ rand_i;  // tag mixed with this cycle's random word

  always @(posedge clk) begin
    if (!rst_lck) begin
      ack_o    <= 1'b0;
      wait_cnt <= 0;
    end else if (ack_o) begin
      ack_o    <= 1'b0;  // one cycle acknowledge
      wait_cnt <= 0;
    end else if (cyc_i && stb_i) begin
      if (wait_cnt == WAIT_CYCLES) begin
        ack_o <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end else begin
      wait_cnt <= 0;
    end
  end

endmodule

module soc_bus_tb;

  localparam int ACK_TIMEOUT = 20;
  localparam int IRQ_TIMEOUT = 10;
  localparam int RST_TIMEOUT = 64;

  localparam soc_bus_pkg::word_t ROM_TAG   = 16'h0f00;
  localparam soc_bus_pkg::word_t VGA_TAG   = 16'h5a00;
  localparam soc_bus_pkg::word_t KEYB_TAG  = 16'hc300;
  localparam soc_bus_pkg::word_t SDRAM_TAG = 16'h3c00;

  logic                                     clk;
  logic                                     rst_lck;
  soc_bus_pkg::irq_vec_t                    intv;
  soc_bus_pkg::bus_addr_t                   m_adr;
  soc_bus_pkg::word_t                       m_wdat;
  soc_bus_pkg::sel_t                        m_sel;
  logic                                     m_we;
  logic                                     m_cyc;
  logic                                     m_stb;
  logic                                     inta;
  soc_bus_pkg::word_t                       m_rdat;
  logic                                     m_ack;
  soc_bus_pkg::bus_addr_t                   s_adr;
  soc_bus_pkg::word_t                       s_dat;
  soc_bus_pkg::sel_t                        s_sel;
  logic                                     s_we;
  logic [soc_bus_pkg::NUM_SLAVES-1:0]       s_cyc;
  logic [soc_bus_pkg::NUM_SLAVES-1:0]       s_stb;
  logic [soc_bus_pkg::NUM_SLAVES-1:0]       s_ack;
  soc_bus_pkg::word_t [soc_bus_pkg::NUM_SLAVES-1:0] s_rdat;
  logic                                     sys_rst;
  logic                                     intr;
  soc_bus_pkg::irq_id_t                     iid;
  logic                                     rom_ack;
  logic                                     vga_ack;
  logic                                     keyb_ack;
  logic                                     sdram_ack;
  soc_bus_pkg::word_t                       rom_rdat;
  soc_bus_pkg::word_t                       vga_rdat;
  soc_bus_pkg::word_t                       keyb_rdat;
  soc_bus_pkg::word_t                       sdram_rdat;
  soc_bus_pkg::word_t                       rand_word;
  integer                                   seed = 32'hc605_d402;

  assign s_ack  = {sdram_ack, keyb_ack, vga_ack, rom_ack};  // slave_sel_e order
  assign s_rdat = {sdram_rdat, keyb_rdat, vga_rdat, rom_rdat};

  clock_gen #(.PERIOD_NS(8)) u_clock_gen (.clk_o(clk));

  soc_bus_top dut (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .intv_i    (intv),
    .m_adr_i   (m_adr),
    .m_dat_i   (m_wdat),
    .m_sel_i   (m_sel),
    .m_we_i    (m_we),
    .m_cyc_i   (m_cyc),
    .m_stb_i   (m_stb),
    .inta_i    (inta),
    .m_dat_o   (m_rdat),
    .m_ack_o   (m_ack),
    .s_adr_o   (s_adr),
    .s_dat_o   (s_dat),
    .s_sel_o   (s_sel),
    .s_we_o    (s_we),
    .s_cyc_o   (s_cyc),
    .s_stb_o   (s_stb),
    .s_ack_i   (s_ack),
    .s_rdat_i  (s_rdat),
    .sys_rst_o (sys_rst),
    .intr_o    (intr),
    .iid_o     (iid)
  );

  slave_model #(.WAIT_CYCLES(0), .TAG(ROM_TAG)) u_rom (
    .clk(clk), .rst_lck(rst_lck), .cyc_i(s_cyc[0]), .stb_i(s_stb[0]),
    .rand_i(rand_word), .ack_o(rom_ack), .rdat_o(rom_rdat)
  );
  slave_model #(.WAIT_CYCLES(2), .TAG(VGA_TAG)) u_vga (
    .clk(clk), .rst_lck(rst_lck), .cyc_i(s_cyc[1]), .stb_i(s_stb[1]),
    .rand_i(rand_word), .ack_o(vga_ack), .rdat_o(vga_rdat)
  );
  slave_model #(.WAIT_CYCLES(1), .TAG(KEYB_TAG)) u_keyb (
    .clk(clk), .rst_lck(rst_lck), .cyc_i(s_cyc[2]), .stb_i(s_stb[2]),
    .rand_i(rand_word), .ack_o(keyb_ack), .rdat_o(keyb_rdat)
  );
  slave_model #(.WAIT_CYCLES(2), .TAG(SDRAM_TAG)) u_sdram (
    .clk(clk), .rst_lck(rst_lck), .cyc_i(s_cyc[3]), .stb_i(s_stb[3]),
    .rand_i(rand_word), .ack_o(sdram_ack), .rdat_o(sdram_rdat)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic word_check(input string name, input soc_bus_pkg::word_t got,
                            input soc_bus_pkg::word_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic addr_check(input string name, input soc_bus_pkg::bus_addr_t got,
                            input soc_bus_pkg::bus_addr_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic lanes_check(input string name, input soc_bus_pkg::sel_t got,
                             input soc_bus_pkg::sel_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic slave_check(input string name, input soc_bus_pkg::slave_sel_e got,
                             input soc_bus_pkg::slave_sel_e exp);
    if (got !== exp) abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic id_check(input string name, input soc_bus_pkg::irq_id_t got,
                          input soc_bus_pkg::irq_id_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic flag_check(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic count_check(input string name, input int got, input int exp);
    if (got != exp) abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  // io tag on top, byte address bits 19:1 below
  function automatic soc_bus_pkg::bus_addr_t tag_addr(input logic io, input logic [19:0] byte_adr);
    return {io, byte_adr[19:1]};
  endfunction

  function automatic soc_bus_pkg::word_t tag_of(input soc_bus_pkg::slave_sel_e slv);
    case (slv)
      soc_bus_pkg::SLV_ROM:   return ROM_TAG;
      soc_bus_pkg::SLV_VGA:   return VGA_TAG;
      soc_bus_pkg::SLV_KEYB:  return KEYB_TAG;
      soc_bus_pkg::SLV_SDRAM: return SDRAM_TAG;
      default:                return '0;
    endcase
  endfunction

  // no strobe at all reads as the default slave
  function automatic soc_bus_pkg::slave_sel_e strobe_owner(
    input logic [soc_bus_pkg::NUM_SLAVES-1:0] vec
  );
    soc_bus_pkg::slave_sel_e owner;
    owner = soc_bus_pkg::SLV_DEFAULT;
    for (int i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin
      if (vec[i]) owner = soc_bus_pkg::slave_sel_e'(i);
    end
    return owner;
  endfunction

  task automatic reset_gating_check;
    flag_check("sys_rst_o", sys_rst, 1'b1);
    flag_check("s_stb_o any", |s_stb, 1'b0);
    flag_check("s_cyc_o any", |s_cyc, 1'b0);
    flag_check("m_ack_o", m_ack, 1'b0);
  endtask

  task automatic reset_test;
    int  edges;
    logic released;
    edges    = 0;
    released = 1'b0;
    @(posedge clk);
    m_adr <= tag_addr(1'b0, 20'hf8000);  // rom cycle held against the reset
    m_cyc <= 1'b1;
    m_stb <= 1'b1;
    @(negedge clk);
    reset_gating_check();
    @(posedge clk);
    rst_lck <= 1'b1;
    @(negedge clk);
    reset_gating_check();
    while (!released) begin
      if (edges == RST_TIMEOUT) abort_run("system reset was never released");
      @(posedge clk);
      if (edges == 0) begin
        m_cyc <= 1'b0;
        m_stb <= 1'b0;
      end
      edges++;
      @(negedge clk);
      released = !sys_rst;
    end
    count_check("sys_rst_o release edges", edges, soc_bus_pkg::DEBOUNCE_CYCLES + 1);
  endtask

  task automatic bus_cycle(input logic io, input logic [19:0] byte_adr, input logic we,
                           input soc_bus_pkg::sel_t lanes,
                           input soc_bus_pkg::slave_sel_e exp_slave);
    soc_bus_pkg::bus_addr_t adr;
    soc_bus_pkg::word_t     wdat;
    soc_bus_pkg::word_t     rnd;
    soc_bus_pkg::word_t     exp_rdat;
    int                     waited;
    adr      = tag_addr(io, byte_adr);
    wdat     = soc_bus_pkg::word_t'($random(seed));
    rnd      = soc_bus_pkg::word_t'($random(seed));
    exp_rdat = (exp_slave == soc_bus_pkg::SLV_DEFAULT) ? 16'hffff : (tag_of(exp_slave) ^ rnd);
    waited   = 0;
    @(posedge clk);
    m_adr     <= adr;
    m_wdat    <= wdat;
    m_sel     <= lanes;
    m_we      <= we;
    m_cyc     <= 1'b1;
    m_stb     <= 1'b1;
    rand_word <= rnd;
    @(negedge clk);
    if ($countones(s_stb) > 1) abort_run("more than one slave strobe is high");
    slave_check("s_stb_o owner", strobe_owner(s_stb), exp_slave);
    slave_check("s_cyc_o owner", strobe_owner(s_cyc), exp_slave);
    addr_check("s_adr_o", s_adr, adr);
    word_check("s_dat_o", s_dat, wdat);
    lanes_check("s_sel_o", s_sel, lanes);
    flag_check("s_we_o", s_we, we);
    while (!m_ack) begin
      if (waited == ACK_TIMEOUT) abort_run("no bus acknowledge within the timeout");
      @(negedge clk);
      waited++;
    end
    if (!we) word_check("m_dat_o", m_rdat, exp_rdat);
    @(posedge clk);
    m_cyc <= 1'b0;
    m_stb <= 1'b0;
    m_we  <= 1'b0;
  endtask

  task automatic decode_test;
    bus_cycle(1'b0, 20'hf8000, 1'b0, 2'b11, soc_bus_pkg::SLV_ROM);
    bus_cycle(1'b0, 20'hc4000, 1'b0, 2'b11, soc_bus_pkg::SLV_ROM);
    bus_cycle(1'b0, 20'hb0000, 1'b0, 2'b11, soc_bus_pkg::SLV_VGA);
    bus_cycle(1'b1, 20'h003d4, 1'b0, 2'b01, soc_bus_pkg::SLV_VGA);
    bus_cycle(1'b1, 20'h00060, 1'b0, 2'b01, soc_bus_pkg::SLV_KEYB);
    bus_cycle(1'b1, 20'h00064, 1'b0, 2'b01, soc_bus_pkg::SLV_KEYB);
    // port 0x61 is the odd lane of word 0x30, so 0x62 is the first unclaimed port
    bus_cycle(1'b1, 20'h00062, 1'b0, 2'b01, soc_bus_pkg::SLV_DEFAULT);
    bus_cycle(1'b0, 20'h12340, 1'b0, 2'b11, soc_bus_pkg::SLV_SDRAM);
  endtask

  task automatic write_test;
    bus_cycle(1'b0, 20'h12340, 1'b1, 2'b11, soc_bus_pkg::SLV_SDRAM);
    bus_cycle(1'b0, 20'hb8000, 1'b1, 2'b10, soc_bus_pkg::SLV_VGA);
    bus_cycle(1'b1, 20'h00064, 1'b1, 2'b01, soc_bus_pkg::SLV_KEYB);
    bus_cycle(1'b0, 20'hf0002, 1'b1, 2'b11, soc_bus_pkg::SLV_ROM);
  endtask

  task automatic unmapped_test;
    bus_cycle(1'b1, 20'h003f8, 1'b0, 2'b01, soc_bus_pkg::SLV_DEFAULT);
    bus_cycle(1'b1, 20'h003f8, 1'b1, 2'b01, soc_bus_pkg::SLV_DEFAULT);
  endtask

  task automatic irq_test;
    int waited;
    waited = 0;
    @(posedge clk);
    intv <= 8'b0010_0100;  // lines 5 and 2
    @(negedge clk);
    while (!intr) begin
      if (waited == IRQ_TIMEOUT) abort_run("interrupt request never reached intr_o");
      @(negedge clk);
      waited++;
    end
    id_check("iid_o", iid, 3'd2);
    @(posedge clk);
    m_adr <= tag_addr(1'b0, 20'hf8000);  // rom cycle held during the acknowledge
    m_cyc <= 1'b1;
    m_stb <= 1'b1;
    inta  <= 1'b1;
    @(negedge clk);
    word_check("m_dat_o vector", m_rdat, 16'h000a);
    flag_check("s_stb_o any", |s_stb, 1'b0);
    flag_check("s_cyc_o any", |s_cyc, 1'b0);
    flag_check("m_ack_o", m_ack, 1'b0);
    @(posedge clk);
    m_cyc  <= 1'b0;
    m_stb  <= 1'b0;
    inta   <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (iid != 3'd5) begin
      if (waited == IRQ_TIMEOUT) abort_run("iid_o never moved on after the acknowledge");
      @(negedge clk);
      waited++;
    end
    flag_check("intr_o", intr, 1'b1);  // line 5 still pending
    @(posedge clk);
    inta <= 1'b1;
    @(negedge clk);
    word_check("m_dat_o vector", m_rdat, 16'h000d);
    @(posedge clk);
    inta   <= 1'b0;
    intv   <= '0;
    waited = 0;
    @(negedge clk);
    while (intr) begin
      if (waited == IRQ_TIMEOUT) abort_run("intr_o stayed high after the last acknowledge");
      @(negedge clk);
      waited++;
    end
  endtask

  initial begin
    rst_lck   = 1'b0;
    intv      = '0;
    m_adr     = '0;
    m_wdat    = '0;
    m_sel     = '0;
    m_we      = 1'b0;
    m_cyc     = 1'b0;
    m_stb     = 1'b0;
    inta      = 1'b0;
    rand_word = '0;
    reset_test();
    decode_test();
    write_test();
    unmapped_test();
    irq_test();
    @(posedge clk);
    if (dut.u_bus_switch.u_soc_bus_sva.fail_cnt != 0) begin
      abort_run("a bound bus switch assertion failed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* test/soc_bus_sva.sv */
// bus switch assertions on strobe exclusivity, acknowledge origin and reset gating
`timescale 1ns/10ps

module soc_bus_sva (
  input logic                               clk,
  input logic                               sys_rst_i,
  input logic                               m_stb_i,
  input logic                               m_ack_i,
  input logic [soc_bus_pkg::NUM_SLAVES-1:0] s_stb_i
);

  int fail_cnt = 0;  // assertion failures seen so far

  // one slave at a time
  a_one_strobe: assert property (@(posedge clk) $onehot0(s_stb_i))
    else begin
      $error("more than one slave strobe is high");
      fail_cnt++;
    end

  a_ack_origin: assert property (@(posedge clk) $rose(m_ack_i) |-> m_stb_i)
    else begin
      $error("master acknowledge rose without a master strobe");
      fail_cnt++;
    end

  // nothing reaches a slave while the system reset is held
  a_reset_gate: assert property (@(posedge clk) sys_rst_i |-> (s_stb_i == '0))
    else begin
      $error("slave strobe high during system reset");
      fail_cnt++;
    end

endmodule

bind bus_switch soc_bus_sva u_soc_bus_sva (
  .clk       (clk),
  .sys_rst_i (sys_rst_i),
  .m_stb_i   (m_stb_i),
  .m_ack_i   (m_ack_o),
  .s_stb_i   (s_stb_o)
);

/* test/clock_gen.sv */
// testbench clock source, free running square wave
`timescale 1ns/10ps

module clock_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2) clk_o = ~clk_o;  // half period per toggle
  end

endmodule

/* source/soc_bus_top.sv */
// system bus fabric top, debounced reset, address decode, interrupt controller and switch
`timescale 1ns/10ps

module soc_bus_top (
  input  logic                                          clk,
  input  logic                                          rst_lck,
  input  soc_bus_pkg::irq_vec_t                         intv_i,

  // cpu master
  input  soc_bus_pkg::bus_addr_t                        m_adr_i,
  input  soc_bus_pkg::word_t                            m_dat_i,
  input  soc_bus_pkg::sel_t                             m_sel_i,
  input  logic                                          m_we_i,
  input  logic                                          m_cyc_i,
  input  logic                                          m_stb_i,
  input  logic                                          inta_i,
  output soc_bus_pkg::word_t                            m_dat_o,
  output logic                                          m_ack_o,

  // slaves
  output soc_bus_pkg::bus_addr_t                        s_adr_o,
  output soc_bus_pkg::word_t                            s_dat_o,
  output soc_bus_pkg::sel_t                             s_sel_o,
  output logic                                          s_we_o,
  output logic [soc_bus_pkg::NUM_SLAVES-1:0]            s_cyc_o,
  output logic [soc_bus_pkg::NUM_SLAVES-1:0]            s_stb_o,
  input  logic [soc_bus_pkg::NUM_SLAVES-1:0]            s_ack_i,
  input  soc_bus_pkg::word_t [soc_bus_pkg::NUM_SLAVES-1:0] s_rdat_i,

  output logic                                          sys_rst_o,
  output logic                                          intr_o,
  output soc_bus_pkg::irq_id_t                          iid_o
);

  soc_bus_pkg::slave_sel_e slave_sel;  // decoded target of the current cycle

  reset_debounce u_reset_debounce (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .sys_rst_o (sys_rst_o)
  );

  addr_decoder u_addr_decoder (
    .m_adr_i     (m_adr_i),
    .slave_sel_o (slave_sel)
  );

  intr_controller u_intr_controller (
    .clk       (clk),
    .sys_rst_i (sys_rst_o),
    .intv_i    (intv_i),
    .inta_i    (inta_i),
    .intr_o    (intr_o),
    .iid_o     (iid_o)
  );

  bus_switch u_bus_switch (
    .clk         (clk),
    .sys_rst_i   (sys_rst_o),
    .slave_sel_i (slave_sel),
    .m_adr_i     (m_adr_i),
    .m_dat_i     (m_dat_i),
    .m_sel_i     (m_sel_i),
    .m_we_i      (m_we_i),
    .m_cyc_i     (m_cyc_i),
    .m_stb_i     (m_stb_i),
    .inta_i      (inta_i),
    .iid_i       (iid_o),     // vector number for the acknowledge read
    .m_dat_o     (m_dat_o),
    .m_ack_o     (m_ack_o),
    .s_adr_o     (s_adr_o),
    .s_dat_o     (s_dat_o),
    .s_sel_o     (s_sel_o),
    .s_we_o      (s_we_o),
    .s_cyc_o     (s_cyc_o),
    .s_stb_o     (s_stb_o),
    .s_ack_i     (s_ack_i),
    .s_rdat_i    (s_rdat_i)
  );

endmodule

/* source/bus_switch.sv */
// bus switch, routes master strobes to the selected slave and muxes back data and acknowledge
`timescale 1ns/10ps

module bus_switch (
  input  logic                                          clk,
  input  logic                                          sys_rst_i,
  input  soc_bus_pkg::slave_sel_e                       slave_sel_i,

  // master side
  input  soc_bus_pkg::bus_addr_t                        m_adr_i,
  input  soc_bus_pkg::word_t                            m_dat_i,
  input  soc_bus_pkg::sel_t                             m_sel_i,
  input  logic                                          m_we_i,
  input  logic                                          m_cyc_i,
  input  logic                                          m_stb_i,
  input  logic                                          inta_i,
  input  soc_bus_pkg::irq_id_t                          iid_i,
  output soc_bus_pkg::word_t                            m_dat_o,
  output logic                                          m_ack_o,

  // slave side, shared lines
  output soc_bus_pkg::bus_addr_t                        s_adr_o,
  output soc_bus_pkg::word_t                            s_dat_o,
  output soc_bus_pkg::sel_t                             s_sel_o,
  output logic                                          s_we_o,

  // slave side, one per slave
  output logic [soc_bus_pkg::NUM_SLAVES-1:0]            s_cyc_o,
  output logic [soc_bus_pkg::NUM_SLAVES-1:0]            s_stb_o,
  input  logic [soc_bus_pkg::NUM_SLAVES-1:0]            s_ack_i,
  input  soc_bus_pkg::word_t [soc_bus_pkg::NUM_SLAVES-1:0] s_rdat_i
);

  logic bus_open;  // cycles may reach a slave
  logic def_ack;   // default slave answers on its strobe

  // no slave sees a cycle in reset or while the cpu takes an interrupt
  assign bus_open = ~sys_rst_i & ~inta_i;

  // address, data, lanes and direction go to every slave
  assign s_adr_o = m_adr_i;
  assign s_dat_o = m_dat_i;
  assign s_sel_o = m_sel_i;
  assign s_we_o  = m_we_i;

  always_comb begin
    s_cyc_o = '0;
    s_stb_o = '0;
    for (int i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin
      if (int'(slave_sel_i) == i) begin
        s_cyc_o[i] = m_cyc_i & bus_open;
        s_stb_o[i] = m_stb_i & bus_open;
      end
    end
  end

  assign def_ack = (slave_sel_i == soc_bus_pkg::SLV_DEFAULT) & m_cyc_i & m_stb_i & bus_open;

  // return path, zero added latency
  always_comb begin
    m_dat_o = soc_bus_pkg::DEFAULT_RDATA;
    m_ack_o = def_ack;
    for (int i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin
      if (int'(slave_sel_i) == i) begin
        m_dat_o = s_rdat_i[i];
        m_ack_o = s_ack_i[i] & s_cyc_o[i] & s_stb_o[i];  // stray acks are dropped
      end
    end
    if (inta_i) begin
      m_dat_o = soc_bus_pkg::INTA_VEC_BASE + soc_bus_pkg::word_t'(iid_i);  // vector read
    end
  end

endmodule

/* source/intr_controller.sv */
// simple interrupt controller, latches request edges and reports the lowest pending line
`timescale 1ns/10ps

module intr_controller (
  input  logic                  clk,
  input  logic                  sys_rst_i,
  input  soc_bus_pkg::irq_vec_t intv_i,
  input  logic                  inta_i,
  output logic                  intr_o,
  output soc_bus_pkg::irq_id_t  iid_o
);

  soc_bus_pkg::irq_vec_t intv_q;    // request lines seen last edge
  soc_bus_pkg::irq_vec_t pending;
  soc_bus_pkg::irq_vec_t req_rise;
  soc_bus_pkg::irq_vec_t ack_clr;
  soc_bus_pkg::irq_id_t  low_id;
  logic                  inta_q;
  logic                  ack_rise;

  assign req_rise = intv_i & ~intv_q;
  assign ack_rise = inta_i & ~inta_q;  // first clock of the acknowledge

  always_comb begin
    ack_clr = '0;
    if (ack_rise) begin
      ack_clr[iid_o] = 1'b1;  // the number the cpu is reading right now
    end
  end

  // scan downward so the lowest pending number is left in low_id
  always_comb begin
    low_id = '0;
    for (int i = soc_bus_pkg::NUM_IRQ - 1; i >= 0; i--) begin
      if (pending[i]) begin
        low_id = soc_bus_pkg::irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      intv_q  <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
      intr_o  <= 1'b0;
      iid_o   <= '0;
    end else begin
      intv_q  <= intv_i;
      inta_q  <= inta_i;
      pending <= (pending & ~ack_clr) | req_rise;  // a new edge beats the clear
      intr_o  <= |pending;
      iid_o   <= low_id;
    end
  end

endmodule

/* source/addr_decoder.sv */
// address window decoder, picks one slave per bus cycle in fixed priority order
`timescale 1ns/10ps

module addr_decoder (
  input  soc_bus_pkg::bus_addr_t  m_adr_i,
  output soc_bus_pkg::slave_sel_e slave_sel_o
);

  logic rom_hit;
  logic vga_hit;
  logic keyb_hit;
  logic sdram_hit;

  // bits under the mask must equal the window bits
  function automatic logic win_hit(
    input soc_bus_pkg::bus_addr_t adr,
    input soc_bus_pkg::bus_addr_t win,
    input soc_bus_pkg::bus_addr_t mask
  );
    return ((adr ^ win) & mask) == '0;
  endfunction

  assign rom_hit  = win_hit(m_adr_i, soc_bus_pkg::ROM_MEM_HI_ADDR, soc_bus_pkg::ROM_MEM_HI_MASK)
                  | win_hit(m_adr_i, soc_bus_pkg::ROM_MEM_LO_ADDR, soc_bus_pkg::ROM_MEM_LO_MASK);
  assign vga_hit  = win_hit(m_adr_i, soc_bus_pkg::VGA_MEM_ADDR, soc_bus_pkg::VGA_MEM_MASK)
                  | win_hit(m_adr_i, soc_bus_pkg::VGA_IO_ADDR, soc_bus_pkg::VGA_IO_MASK);
  assign keyb_hit = win_hit(m_adr_i, soc_bus_pkg::KEYB_IO_ADDR, soc_bus_pkg::KEYB_IO_MASK);
  assign sdram_hit = win_hit(m_adr_i, soc_bus_pkg::SDRAM_MEM_ADDR, soc_bus_pkg::SDRAM_MEM_MASK);

  // first match wins, sdram takes the memory leftovers
  always_comb begin
    if (rom_hit) begin
      slave_sel_o = soc_bus_pkg::SLV_ROM;
    end else if (vga_hit) begin
      slave_sel_o = soc_bus_pkg::SLV_VGA;
    end else if (keyb_hit) begin
      slave_sel_o = soc_bus_pkg::SLV_KEYB;
    end else if (sdram_hit) begin
      slave_sel_o = soc_bus_pkg::SLV_SDRAM;
    end else begin
      slave_sel_o = soc_bus_pkg::SLV_DEFAULT;  // unmapped io port
    end
  end

endmodule

/* source/reset_debounce.sv */
// power-on reset debounce, holds the system reset for a fixed count after lock release
`timescale 1ns/10ps

module reset_debounce (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_o
);

  soc_bus_pkg::dbnc_cnt_t hold_cnt;  // cycles left before release

  // rst_lck low reloads the count and raises reset at once
  // sys_rst_o drops at the DEBOUNCE_CYCLES+1-th edge that sees rst_lck high
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      hold_cnt  <= soc_bus_pkg::DEBOUNCE_LOAD;
      sys_rst_o <= 1'b1;
    end else begin
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      sys_rst_o <= (hold_cnt != '0);  // follows the count one edge late
    end
  end

endmodule

/* source/soc_bus_pkg.sv */
// system bus package with widths, data types, slave windows and reset/interrupt constants
package soc_bus_pkg;

  localparam int WORD_W     = 16;
  localparam int ADDR_W     = 20;  // io tag on top, 19-bit word address below
  localparam int SEL_W      = 2;
  localparam int NUM_IRQ    = 8;
  localparam int IRQ_ID_W   = $clog2(NUM_IRQ);
  localparam int NUM_SLAVES = 4;   // default slave lives inside the switch

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [ADDR_W-1:0]   bus_addr_t;
  typedef logic [SEL_W-1:0]    sel_t;
  typedef logic [NUM_IRQ-1:0]  irq_vec_t;
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // order is also the decode priority
  typedef enum logic [2:0] {
    SLV_ROM     = 3'd0,
    SLV_VGA     = 3'd1,
    SLV_KEYB    = 3'd2,
    SLV_SDRAM   = 3'd3,
    SLV_DEFAULT = 3'd4
  } slave_sel_e;

  // address/mask windows, hit when (adr ^ addr) & mask == 0
  // bit 19 is the io tag, bits 18:0 hold byte address bits 19:1
  localparam bus_addr_t ROM_MEM_HI_ADDR = 20'h7_8000;  // mem 0xf0000 - 0xfffff
  localparam bus_addr_t ROM_MEM_HI_MASK = 20'hf_8000;
  localparam bus_addr_t ROM_MEM_LO_ADDR = 20'h6_0000;  // mem 0xc0000 - 0xcffff
  localparam bus_addr_t ROM_MEM_LO_MASK = 20'hf_8000;

  localparam bus_addr_t VGA_MEM_ADDR    = 20'h5_0000;  // mem 0xa0000 - 0xbffff
  localparam bus_addr_t VGA_MEM_MASK    = 20'hf_0000;
  localparam bus_addr_t VGA_IO_ADDR     = 20'h8_01e0;  // io 0x3c0 - 0x3df
  localparam bus_addr_t VGA_IO_MASK     = 20'h8_7ff0;

  localparam bus_addr_t KEYB_IO_ADDR    = 20'h8_0030;  // io 0x60 and 0x64
  localparam bus_addr_t KEYB_IO_MASK    = 20'h8_7ffd;

  localparam bus_addr_t SDRAM_MEM_ADDR  = 20'h0_0000;  // any memory cycle
  localparam bus_addr_t SDRAM_MEM_MASK  = 20'h8_0000;

  // power-on reset hold
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES + 1);

  typedef logic [DEBOUNCE_W-1:0] dbnc_cnt_t;

  localparam dbnc_cnt_t DEBOUNCE_LOAD = dbnc_cnt_t'(DEBOUNCE_CYCLES);

  // responses returned to the cpu
  localparam word_t DEFAULT_RDATA = 16'hffff;  // unmapped cycles read all ones
  localparam word_t INTA_VEC_BASE = 16'h0008;  // vector word is base plus irq number

endpackage
